//--- rtl/noc_pkg.sv
package noc_pkg;

    localparam int V_NUM     = 4;
    localparam int BUF_DEPTH = 4;   // also side queue depth, one-flit packets
    localparam int PAY_W     = 32;
    localparam int FLIT_W    = 2 + V_NUM + PAY_W;

    localparam int NX  = 4;
    localparam int NY  = 4;
    localparam int X_W = 2;
    localparam int Y_W = 2;

    // flags on top, one-hot vc right above the payload
    localparam int FLG_HDR  = FLIT_W - 1;
    localparam int FLG_TAIL = FLIT_W - 2;
    localparam int VC_LSB   = PAY_W;

    // header payload, class byte 31:24 is not used here
    localparam int ROUTE_LSB = 16;  // low 3 bits of routing byte
    localparam int DST_X_LSB = 12;
    localparam int DST_Y_LSB = 8;
    localparam int SRC_X_LSB = 4;
    localparam int SRC_Y_LSB = 0;

    localparam int PTR_W = $clog2(BUF_DEPTH);
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    typedef logic [FLIT_W-1:0] flit_t;
    typedef logic [V_NUM-1:0]  vc_mask_t;
    typedef logic [X_W-1:0]    coord_x_t;
    typedef logic [Y_W-1:0]    coord_y_t;
    typedef logic [PTR_W-1:0]  buf_ptr_t;
    typedef logic [CNT_W-1:0]  buf_cnt_t;

    typedef enum logic [2:0] {
        LOCAL = 3'd0,
        EAST  = 3'd1,
        NORTH = 3'd2,
        WEST  = 3'd3,
        SOUTH = 3'd4
    } port_t;

    localparam int PORT_W = $bits(port_t);

endpackage

//--- rtl/header_decoder.sv
`timescale 1ns/100ps

module header_decoder (
    input  noc_pkg::flit_t    flit_in,
    input  logic              flit_we,
    output noc_pkg::vc_mask_t vc_num,
    output logic              is_hdr,
    output logic              is_tail,
    output noc_pkg::port_t    dest_port,
    output noc_pkg::coord_x_t dst_x,
    output noc_pkg::coord_y_t dst_y,
    output noc_pkg::coord_x_t src_x,
    output noc_pkg::coord_y_t src_y,
    output noc_pkg::vc_mask_t hdr_wr
);
    import noc_pkg::*;

    assign vc_num  = flit_in[VC_LSB +: V_NUM];
    assign is_hdr  = flit_in[FLG_HDR];
    assign is_tail = flit_in[FLG_TAIL];

    // routing and address fields only mean something on a header
    assign dest_port = port_t'(flit_in[ROUTE_LSB +: PORT_W]);
    assign dst_x     = flit_in[DST_X_LSB +: X_W];
    assign dst_y     = flit_in[DST_Y_LSB +: Y_W];
    assign src_x     = flit_in[SRC_X_LSB +: X_W];
    assign src_y     = flit_in[SRC_Y_LSB +: Y_W];

    assign hdr_wr = (flit_we && is_hdr) ? vc_num : '0;  // strobe for side queues

endmodule

//--- rtl/vc_flit_buffer.sv
`timescale 1ns/100ps

module vc_flit_buffer (
    input  logic              clk,
    input  logic              reset,
    input  noc_pkg::flit_t    wr_data,
    input  noc_pkg::vc_mask_t wr_vc,
    input  logic              wr_en,
    input  noc_pkg::vc_mask_t rd_vc,
    output noc_pkg::flit_t    rd_data,
    output noc_pkg::vc_mask_t vc_not_empty
);
    import noc_pkg::*;

    localparam int IDX_W  = $clog2(V_NUM);
    localparam int ADDR_W = $clog2(V_NUM * BUF_DEPTH);

    flit_t              mem [V_NUM*BUF_DEPTH];
    buf_ptr_t           wr_ptr [V_NUM];
    buf_ptr_t           rd_ptr [V_NUM];
    buf_cnt_t           count [V_NUM];
    logic [IDX_W-1:0]   wr_idx;
    logic [IDX_W-1:0]   rd_idx;
    logic [ADDR_W-1:0]  wr_addr;
    logic [ADDR_W-1:0]  rd_addr;
    logic               rd_en;
    vc_mask_t           wr_hit;
    vc_mask_t           full;

    always_comb begin
        wr_idx = '0;
        rd_idx = '0;
        for (int v = 0; v < V_NUM; v++) begin
            if (wr_vc[v])
                wr_idx = IDX_W'(v);
            if (rd_vc[v])
                rd_idx = IDX_W'(v);
            vc_not_empty[v] = (count[v] != '0);
            full[v]         = (count[v] == buf_cnt_t'(BUF_DEPTH));
        end
    end

    // slice per vc, depth is a power of two
    assign wr_addr = {wr_idx, wr_ptr[wr_idx]};
    assign rd_addr = {rd_idx, rd_ptr[rd_idx]};
    assign rd_en   = |rd_vc;
    assign wr_hit  = wr_en ? wr_vc : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int v = 0; v < V_NUM; v++) begin
                wr_ptr[v] <= '0;
                rd_ptr[v] <= '0;
                count[v]  <= '0;
            end
        end else begin
            for (int v = 0; v < V_NUM; v++) begin
                if (wr_hit[v])
                    wr_ptr[v] <= wr_ptr[v] + 1'b1;  // wraps inside the slice
                if (rd_vc[v])
                    rd_ptr[v] <= rd_ptr[v] + 1'b1;
                if (wr_hit[v] && !rd_vc[v])
                    count[v] <= count[v] + 1'b1;
                else if (!wr_hit[v] && rd_vc[v])
                    count[v] <= count[v] - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        if (rd_en)
            rd_data <= mem[rd_addr];    // one cycle after the grant edge
    end

    // upstream credits must keep a vc from overflowing
    a_no_write_full: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> (wr_vc & full) == '0)
        else $error("flit written into a full vc");

    a_no_read_empty: assert property (@(posedge clk) disable iff (reset)
        (rd_vc & ~vc_not_empty) == '0)
        else $error("grant on an empty vc");

    a_rd_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(rd_vc))
        else $error("more than one vc granted");

endmodule

//--- rtl/vc_info_fifo.sv
`timescale 1ns/100ps

module vc_info_fifo #(
    parameter int DATA_W = 1
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [DATA_W-1:0] din,
    input  logic              wr_en,
    input  logic              rd_en,
    output logic [DATA_W-1:0] dout
);
    import noc_pkg::*;

    logic [DATA_W-1:0] mem [BUF_DEPTH];
    buf_ptr_t          wr_ptr;
    buf_ptr_t          rd_ptr;
    buf_cnt_t          count;

    assign dout = mem[rd_ptr]; // head is visible right after the write edge

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            if (wr_en && !rd_en)
                count <= count + 1'b1;
            else if (!wr_en && rd_en)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= din;
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        (wr_en && !rd_en) |-> count != buf_cnt_t'(BUF_DEPTH))
        else $error("side queue overflow");

endmodule

//--- rtl/lookahead_xy_route.sv
`timescale 1ns/100ps

module lookahead_xy_route (
    input  logic              clk,
    input  logic              reset,
    input  noc_pkg::coord_x_t cur_x,
    input  noc_pkg::coord_y_t cur_y,
    input  noc_pkg::coord_x_t dst_x,
    input  noc_pkg::coord_y_t dst_y,
    input  noc_pkg::port_t    dest_port,
    output noc_pkg::port_t    lk_port
);
    import noc_pkg::*;

    coord_x_t nxt_x;
    coord_y_t nxt_y;
    port_t    nxt_port;

    // position of the router behind dest_port, kept inside the mesh
    always_comb begin
        nxt_x = cur_x;
        nxt_y = cur_y;
        case (dest_port)
            EAST:  if (cur_x != coord_x_t'(NX - 1)) nxt_x = cur_x + 1'b1;
            WEST:  if (cur_x != '0) nxt_x = cur_x - 1'b1;
            NORTH: if (cur_y != coord_y_t'(NY - 1)) nxt_y = cur_y + 1'b1;
            SOUTH: if (cur_y != '0) nxt_y = cur_y - 1'b1;
            default: ;
        endcase
    end

    // plain xy from that router
    always_comb begin
        if (dst_x > nxt_x)
            nxt_port = EAST;
        else if (dst_x < nxt_x)
            nxt_port = WEST;
        else if (dst_y > nxt_y)
            nxt_port = NORTH;
        else if (dst_y < nxt_y)
            nxt_port = SOUTH;
        else
            nxt_port = LOCAL;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            lk_port <= LOCAL;
        else
            lk_port <= nxt_port;    // lands with the delayed header strobe
    end

endmodule

//--- rtl/flit_rewrite.sv
`timescale 1ns/100ps

module flit_rewrite (
    input  logic              clk,
    input  logic              reset,
    input  noc_pkg::flit_t    flit_in,
    input  noc_pkg::vc_mask_t rd_vc,
    input  noc_pkg::vc_mask_t assigned_ovc [noc_pkg::V_NUM],
    input  noc_pkg::port_t    lk_port [noc_pkg::V_NUM],
    output noc_pkg::flit_t    flit_out
);
    import noc_pkg::*;

    vc_mask_t          vc_d;    // vc that buffer data came from
    vc_mask_t          ovc_sel;
    logic [PORT_W-1:0] lk_sel;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            vc_d <= '0;
        else
            vc_d <= rd_vc;
    end

    // one-hot select by and-or
    always_comb begin
        ovc_sel = '0;
        lk_sel  = '0;
        for (int v = 0; v < V_NUM; v++) begin
            if (vc_d[v]) begin
                ovc_sel = ovc_sel | assigned_ovc[v];
                lk_sel  = lk_sel | lk_port[v];
            end
        end
    end

    always_comb begin
        flit_out = flit_in;
        flit_out[VC_LSB +: V_NUM] = ovc_sel;
        if (flit_in[FLG_HDR])
            flit_out[ROUTE_LSB +: PORT_W] = lk_sel;  // port for next router
    end

endmodule

//--- rtl/input_port.sv
`timescale 1ns/100ps

module input_port (
    input  logic              clk,
    input  logic              reset,
    input  noc_pkg::coord_x_t cur_x,
    input  noc_pkg::coord_y_t cur_y,
    input  noc_pkg::flit_t    flit_in,
    input  logic              flit_we,
    input  noc_pkg::vc_mask_t ivc_grant,
    input  noc_pkg::vc_mask_t assigned_ovc [noc_pkg::V_NUM],
    output noc_pkg::vc_mask_t ivc_request,
    output noc_pkg::vc_mask_t is_tail,
    output noc_pkg::port_t    dest_port [noc_pkg::V_NUM],
    output noc_pkg::flit_t    flit_out,
    output logic              flit_out_valid
);
    import noc_pkg::*;

    vc_mask_t dec_vc;
    vc_mask_t hdr_wr;
    vc_mask_t hdr_wr_d;
    vc_mask_t flit_wr;
    vc_mask_t tail_wr;
    vc_mask_t dst_pop;
    vc_mask_t dst_pop_d;
    vc_mask_t pkt_active;   // only watched by assertions
    logic     dec_hdr;
    logic     dec_tail;
    port_t    dec_port;
    port_t    lk_new;
    port_t    lk_q [V_NUM];
    coord_x_t dst_x;
    coord_x_t src_x;
    coord_y_t dst_y;
    coord_y_t src_y;
    flit_t    buf_out;
    logic     in_box;
    logic     route_ok;

    header_decoder u_hdr_dec (
        .flit_in   (flit_in),
        .flit_we   (flit_we),
        .vc_num    (dec_vc),
        .is_hdr    (dec_hdr),
        .is_tail   (dec_tail),
        .dest_port (dec_port),
        .dst_x     (dst_x),
        .dst_y     (dst_y),
        .src_x     (src_x),
        .src_y     (src_y),
        .hdr_wr    (hdr_wr)
    );

    vc_flit_buffer u_buf (
        .clk          (clk),
        .reset        (reset),
        .wr_data      (flit_in),
        .wr_vc        (dec_vc),
        .wr_en        (flit_we),
        .rd_vc        (ivc_grant),
        .rd_data      (buf_out),
        .vc_not_empty (ivc_request)
    );

    lookahead_xy_route u_lk_route (
        .clk       (clk),
        .reset     (reset),
        .cur_x     (cur_x),
        .cur_y     (cur_y),
        .dst_x     (dst_x),
        .dst_y     (dst_y),
        .dest_port (dec_port),
        .lk_port   (lk_new)
    );

    flit_rewrite u_rewrite (
        .clk          (clk),
        .reset        (reset),
        .flit_in      (buf_out),
        .rd_vc        (ivc_grant),
        .assigned_ovc (assigned_ovc),
        .lk_port      (lk_q),
        .flit_out     (flit_out)
    );

    assign flit_wr = flit_we ? dec_vc : '0;
    assign tail_wr = (flit_we && dec_tail) ? dec_vc : '0;
    assign dst_pop = ivc_grant & is_tail;  // packet leaves with its tail

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hdr_wr_d       <= '0;
            dst_pop_d      <= '0;
            flit_out_valid <= 1'b0;
            pkt_active     <= '0;
        end else begin
            hdr_wr_d       <= hdr_wr;     // lookahead result is one cycle late
            dst_pop_d      <= dst_pop;    // rewrite still needs the entry
            flit_out_valid <= |ivc_grant;
            pkt_active     <= (pkt_active | hdr_wr) & ~tail_wr;
        end
    end

    for (genvar v = 0; v < V_NUM; v++) begin : g_vc
        logic [PORT_W-1:0] dest_raw;
        logic [PORT_W-1:0] lk_raw;

        vc_info_fifo #(.DATA_W(1)) u_tail_q (
            .clk   (clk),
            .reset (reset),
            .din   (dec_tail),
            .wr_en (flit_wr[v]),
            .rd_en (ivc_grant[v]),
            .dout  (is_tail[v])
        );

        vc_info_fifo #(.DATA_W(PORT_W)) u_dest_q (
            .clk   (clk),
            .reset (reset),
            .din   (dec_port),
            .wr_en (hdr_wr[v]),
            .rd_en (dst_pop[v]),
            .dout  (dest_raw)
        );

        vc_info_fifo #(.DATA_W(PORT_W)) u_lk_q (
            .clk   (clk),
            .reset (reset),
            .din   (lk_new),
            .wr_en (hdr_wr_d[v]),
            .rd_en (dst_pop_d[v]),
            .dout  (lk_raw)
        );

        assign dest_port[v] = port_t'(dest_raw);
        assign lk_q[v]      = port_t'(lk_raw);
    end

    // this router sits in the src/dst box and dest_port heads toward dst
    always_comb begin
        in_box = ((cur_x >= src_x && cur_x <= dst_x) || (cur_x >= dst_x && cur_x <= src_x))
              && ((cur_y >= src_y && cur_y <= dst_y) || (cur_y >= dst_y && cur_y <= src_y));
        case (dec_port)
            LOCAL:   route_ok = (dst_x == cur_x) && (dst_y == cur_y);
            EAST:    route_ok = dst_x > cur_x;
            WEST:    route_ok = dst_x < cur_x;
            NORTH:   route_ok = dst_y > cur_y;
            SOUTH:   route_ok = dst_y < cur_y;
            default: route_ok = 1'b0;
        endcase
    end

    a_hdr_idle_vc: assert property (@(posedge clk) disable iff (reset)
        (hdr_wr & pkt_active) == '0)
        else $error("header flit into an active vc");

    a_body_active_vc: assert property (@(posedge clk) disable iff (reset)
        (flit_we && !dec_hdr) |-> (dec_vc & ~pkt_active) == '0)
        else $error("body or tail flit into an idle vc");

    a_minimal_route: assert property (@(posedge clk) disable iff (reset)
        (|hdr_wr) |-> (in_box && route_ok))
        else $error("non-minimal route on header");

endmodule

//--- sim/tb_input_port.sv
`timescale 1ns/100ps

module tb_input_port;
    import noc_pkg::*;

    localparam int N_PKT           = 60;
    localparam int WATCHDOG_CYCLES = N_PKT * 40;

    logic     clk = 1'b0;
    logic     reset;
    coord_x_t cur_x;
    coord_y_t cur_y;
    flit_t    flit_in;
    logic     flit_we;
    vc_mask_t ivc_grant;
    vc_mask_t assigned_ovc [V_NUM];
    vc_mask_t ivc_request;
    vc_mask_t is_tail;
    port_t    dest_port [V_NUM];
    flit_t    flit_out;
    logic     flit_out_valid;

    flit_t    flit_q [V_NUM][$];    // written and not yet granted
    port_t    hdr_q [V_NUM][$];     // routing port of unfinished packets
    int       remain [V_NUM];       // flits left in the open packet
    int       started = 0;
    int       flits_wr = 0;
    int       errors = 0;
    int       ovc_shift;            // input vc to output vc rotation
    flit_t    pend_flit;
    int       pend_vc;
    logic     pend_valid = 1'b0;

    vc_mask_t exp_request = '0;
    vc_mask_t exp_tail = '0;
    vc_mask_t exp_dest_ok = '0;
    port_t    exp_dest [V_NUM];
    logic     exp_valid = 1'b0;
    flit_t    exp_flit = '0;

    input_port i_input_port (
        .clk            (clk),
        .reset          (reset),
        .cur_x          (cur_x),
        .cur_y          (cur_y),
        .flit_in        (flit_in),
        .flit_we        (flit_we),
        .ivc_grant      (ivc_grant),
        .assigned_ovc   (assigned_ovc),
        .ivc_request    (ivc_request),
        .is_tail        (is_tail),
        .dest_port      (dest_port),
        .flit_out       (flit_out),
        .flit_out_valid (flit_out_valid)
    );

    always #4 clk = ~clk;   // 8 ns period

    // next router's port after one hop along p with x before y
    function automatic port_t next_hop(coord_x_t cx, coord_y_t cy, coord_x_t dx,
                                       coord_y_t dy, port_t p);
        coord_x_t nx;
        coord_y_t ny;
        nx = cx;
        ny = cy;
        if (p == EAST)
            nx = cx + 1'b1;
        else if (p == WEST)
            nx = cx - 1'b1;
        else if (p == NORTH)
            ny = cy + 1'b1;
        else if (p == SOUTH)
            ny = cy - 1'b1;
        if (dx != nx)
            return (dx > nx) ? EAST : WEST;
        if (dy != ny)
            return (dy > ny) ? NORTH : SOUTH;
        return LOCAL;
    endfunction

    function automatic flit_t make_flit(int v, logic hdr, logic tail);
        flit_t    f;
        coord_x_t dx;
        coord_y_t dy;
        f = '0;
        f[PAY_W-1:0]       = $urandom;
        f[FLG_HDR]         = hdr;
        f[FLG_TAIL]        = tail;
        f[VC_LSB +: V_NUM] = vc_mask_t'(1) << v;
        if (hdr) begin
            dx = coord_x_t'($urandom % NX);
            dy = coord_y_t'($urandom % NY);
            f[DST_Y_LSB +: 8] = {2'b00, dx, 2'b00, dy};
            f[SRC_Y_LSB +: 8] = {2'b00, cur_x, 2'b00, cur_y};  // packet starts here
            f[ROUTE_LSB +: PORT_W] = next_hop(cur_x, cur_y, dx, dy, LOCAL);
        end
        return f;
    endfunction

    function automatic bit finished();
        bit idle;
        idle = (started == N_PKT);
        for (int v = 0; v < V_NUM; v++)
            if (remain[v] != 0 || flit_q[v].size() != 0)
                idle = 1'b0;
        return idle;
    endfunction

    // expected outputs for the state after the last edge
    task automatic update_expected();
        flit_t f;
        for (int v = 0; v < V_NUM; v++) begin
            exp_request[v] = (flit_q[v].size() != 0);
            exp_tail[v]    = 1'b0;
            if (flit_q[v].size() != 0) begin
                f = flit_q[v][0];
                exp_tail[v] = f[FLG_TAIL];
            end
            exp_dest_ok[v] = (hdr_q[v].size() != 0);
            if (hdr_q[v].size() != 0)
                exp_dest[v] = hdr_q[v][0];
        end
        exp_valid = pend_valid;
        if (pend_valid) begin
            f = pend_flit;
            f[VC_LSB +: V_NUM] = assigned_ovc[pend_vc];
            if (f[FLG_HDR])
                f[ROUTE_LSB +: PORT_W] = next_hop(cur_x, cur_y, f[DST_X_LSB +: X_W],
                    f[DST_Y_LSB +: Y_W], port_t'(f[ROUTE_LSB +: PORT_W]));
            exp_flit = f;
        end
        pend_valid = 1'b0;
    endtask

    task automatic drive_cycle();
        int    g;
        int    u;
        int    w;
        int    len;
        logic  do_wr;
        flit_t f;
        g = -1;
        if ($urandom % 3 != 0) begin
            u = $urandom % V_NUM;
            if (flit_q[u].size() != 0)
                g = u;
        end
        w = $urandom % V_NUM;
        do_wr = ($urandom % 2 == 0) && (flit_q[w].size() < BUF_DEPTH)
             && (remain[w] != 0 || started < N_PKT);   // credits never overrun a vc
        ivc_grant = '0;
        if (g >= 0) begin
            ivc_grant  = vc_mask_t'(1) << g;
            pend_flit  = flit_q[g].pop_front();
            pend_vc    = g;
            pend_valid = 1'b1;
            if (pend_flit[FLG_TAIL])
                void'(hdr_q[g].pop_front());
        end
        flit_we = do_wr;
        if (do_wr) begin
            if (remain[w] == 0) begin
                len = 1 + int'($urandom % 3);
                f = make_flit(w, 1'b1, len == 1);
                hdr_q[w].push_back(port_t'(f[ROUTE_LSB +: PORT_W]));
                remain[w] = len - 1;
                started++;
            end else begin
                f = make_flit(w, 1'b0, remain[w] == 1);
                remain[w]--;
            end
            flit_q[w].push_back(f);
            flit_in = f;
            flits_wr++;
        end
    endtask

    a_request: assert property (@(posedge clk) disable iff (reset)
        ivc_request == exp_request)
        else begin
            errors++;
            $display("FAIL at %0t: ivc_request %b, expected %b", $time,
                     $sampled(ivc_request), exp_request);
        end

    a_valid: assert property (@(posedge clk) disable iff (reset)
        flit_out_valid == exp_valid)
        else begin
            errors++;
            $display("FAIL at %0t: flit_out_valid %b, expected %b", $time,
                     $sampled(flit_out_valid), exp_valid);
        end

    a_ovc: assert property (@(posedge clk) disable iff (reset)
        exp_valid |-> flit_out[VC_LSB +: V_NUM] == exp_flit[VC_LSB +: V_NUM])
        else begin
            errors++;
            $display("FAIL at %0t: output vc field %b, expected %b", $time,
                     $sampled(flit_out[VC_LSB +: V_NUM]), exp_flit[VC_LSB +: V_NUM]);
        end

    a_flit: assert property (@(posedge clk) disable iff (reset)
        exp_valid |-> flit_out == exp_flit)
        else begin
            errors++;
            $display("FAIL at %0t: flit_out %h, expected %h", $time,
                     $sampled(flit_out), exp_flit);
        end

    for (genvar v = 0; v < V_NUM; v++) begin : g_chk
        a_tail: assert property (@(posedge clk) disable iff (reset)
            exp_request[v] |-> is_tail[v] == exp_tail[v])
            else begin
                errors++;
                $display("FAIL at %0t: vc %0d is_tail %b, expected %b", $time, v,
                         $sampled(is_tail[v]), exp_tail[v]);
            end

        a_dest: assert property (@(posedge clk) disable iff (reset)
            exp_dest_ok[v] |-> dest_port[v] == exp_dest[v])
            else begin
                errors++;
                $display("FAIL at %0t: vc %0d dest_port %0d, expected %0d", $time, v,
                         $sampled(dest_port[v]), exp_dest[v]);
            end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: traffic did not drain within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h19b3_c927));
        reset     = 1'b1;
        cur_x     = 2'd1;
        cur_y     = 2'd2;
        flit_in   = '0;
        flit_we   = 1'b0;
        ivc_grant = '0;
        ovc_shift = 1 + int'($urandom % (V_NUM - 1));  // distinct and never the input vc
        for (int v = 0; v < V_NUM; v++) begin
            remain[v]       = 0;
            assigned_ovc[v] = vc_mask_t'(1) << ((v + ovc_shift) % V_NUM);  // held all run
        end
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        while (!finished()) begin
            update_expected();
            drive_cycle();
            @(posedge clk);
            #1;
        end
        flit_we   = 1'b0;
        ivc_grant = '0;
        repeat (4) begin
            update_expected();  // last flit out and then request back to zero
            @(posedge clk);
            #1;
        end
        $display("%0d packets, %0d flits, %0d check errors", started, flits_wr, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- vlog.f
rtl/noc_pkg.sv
rtl/header_decoder.sv
rtl/vc_flit_buffer.sv
rtl/vc_info_fifo.sv
rtl/lookahead_xy_route.sv
rtl/flit_rewrite.sv
rtl/input_port.sv
sim/tb_input_port.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_input_port -o sim_tb

out=$(./obj_dir/sim_tb) || true
echo "$out"

echo "$out" | grep -q "TEST RESULT: PASS"
